// ==== files.f ====
+incdir+include
hw/ctrl_pkg.sv
hw/pc_counter.sv
hw/op_decoder.sv
hw/stage_slot.sv
hw/fetch_fsm.sv
hw/mem_fsm.sv
hw/ctrl_top.sv
bench/tb_ctrl_top.sv

// ==== Bender.yml ====
package:
  name: ctrl_seq

sources:
  - hw/ctrl_pkg.sv
  - hw/pc_counter.sv
  - hw/op_decoder.sv
  - hw/stage_slot.sv
  - hw/fetch_fsm.sv
  - hw/mem_fsm.sv
  - hw/ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_ctrl_top.sv

// ==== include/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// reference instruction kinds
localparam int K_COMPUTE = 0;
localparam int K_LOAD    = 1;
localparam int K_STORE   = 2;
localparam int K_JUMP    = 3;
localparam int K_ILLEGAL = 4;

//////////////////////////////
// random source
//////////////////////////////
// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// one step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

//////////////////////////////
// reference decode
//////////////////////////////
function automatic int ref_kind(input logic [15:0] word);
    instr_t w;
    w = word;
    if (w.opcode < OP_LOAD_BASE)
        return K_COMPUTE;
    if (w.opcode < OP_STORE_BASE)
        return K_LOAD;
    if (w.opcode < OP_JUMP)
        return K_STORE;
    if (w.opcode == OP_JUMP)
        return K_JUMP;
    return K_ILLEGAL;
endfunction

task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on the first error");
endtask

task automatic stop_on_error(input string msg);
    $display("%s at %0t ns", msg, $time);
    fail_run();
endtask

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
        $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        fail_run();
    end
endtask

`endif

// ==== bench/tb_ctrl_top.sv ====
`timescale 1ns/1ns

module tb_ctrl_top;
    import ctrl_pkg::*;

    localparam int PC_W          = 8;
    localparam int RESET_PC      = 'h10;
    localparam int NUM_FETCH     = 400;
    localparam int SLOW_ACCESSES = 6;
    localparam int MAX_WAIT      = 20000;

    logic                g_clk;
    logic                arst_n;
    logic                i_req;
    logic [PC_W-1:0]     i_addr;
    logic [INSTR_W-1:0]  i_data;
    logic                i_odv;
    logic                d_rd;
    logic                d_wr;
    logic [IMM_W-1:0]    d_addr;
    logic                d_odv;
    logic                rf_we;
    logic [RD_W-1:0]     rf_rd;
    logic                rf_from_mem;
    logic [ALU_OP_W-1:0] alu_op;
    logic                illegal;

    logic [15:0] imem [0:255];
    logic [31:0] lfsr_state;
    logic [7:0]  exp_fetch [$];
    logic [7:0]  exp_acc [$];
    logic [7:0]  exp_wb [$];
    logic [7:0]  obs_fetch [$];
    logic [7:0]  obs_acc [$];
    logic [7:0]  obs_wb [$];
    int          illegal_exp;
    int          illegal_seen;
    int          served_fetch;
    int          served_data;
    int          i_wait;
    int          d_wait;
    logic        i_busy;
    logic        d_busy;
    logic        resp_en;
    logic        overlap_seen;

    `include "tb_ref.svh"

    ctrl_top #(
        .PC_W     (PC_W),
        .RESET_PC (RESET_PC)
    ) dut0 (
        .g_clk       (g_clk),
        .arst_n      (arst_n),
        .i_req       (i_req),
        .i_addr      (i_addr),
        .i_data      (i_data),
        .i_odv       (i_odv),
        .d_rd        (d_rd),
        .d_wr        (d_wr),
        .d_addr      (d_addr),
        .d_odv       (d_odv),
        .rf_we       (rf_we),
        .rf_rd       (rf_rd),
        .rf_from_mem (rf_from_mem),
        .alu_op      (alu_op),
        .illegal     (illegal)
    );

    always #5 g_clk = ~g_clk;

    //////////////////////////////
    // program image
    //////////////////////////////
    // second word carries the target in its low byte
    task automatic place_jump(input logic [7:0] at, input logic [7:0] target);
        logic [7:0] hi;
        hi = 8'(take_bits(8));
        imem[at] = {OP_JUMP, 10'd0};
        imem[int'(at) + 1] = {hi, target};
    endtask

    task automatic fill_memory();
        int         a;
        logic [2:0] pick;
        logic [5:0] op;
        logic [2:0] rd_bits;
        logic [6:0] imm_bits;
        for (a = 0; a < 256; a++)
        begin
            pick = 3'(take_bits(3));
            case (pick)
                3'd4, 3'd5: op = OP_LOAD_BASE + 6'(take_bits(2));
                3'd6:       op = OP_STORE_BASE + 6'(take_bits(2));
                3'd7:       op = OP_JUMP + 6'd1 + 6'(take_bits(5));
                default:    op = 6'(take_bits(4));
            endcase
            rd_bits  = 3'(take_bits(3));
            imm_bits = 7'(take_bits(7));
            imem[a]  = {op, rd_bits, imm_bits};
        end
        place_jump(8'h30, 8'h3c);
        place_jump(8'h6a, 8'h81);
        place_jump(8'hb4, 8'hc9);
        place_jump(8'he8, 8'hf6);
    endtask

    // walks the program in order, two fetches per jump
    task automatic build_expected();
        logic [7:0] pc;
        instr_t     w;
        int         nf;
        pc          = 8'(RESET_PC);
        nf          = 0;
        illegal_exp = 0;
        while (nf < NUM_FETCH)
        begin
            exp_fetch.push_back(pc);
            w  = imem[pc];
            pc = pc + 8'd1;
            nf++;
            case (ref_kind(w))
                K_JUMP:
                begin
                    if (nf < NUM_FETCH)
                    begin
                        exp_fetch.push_back(pc);
                        pc = imem[pc][7:0];
                        nf++;
                    end
                end
                K_COMPUTE: exp_wb.push_back({w.rd, 1'b0, w.opcode[3:0]});
                K_LOAD:
                begin
                    exp_acc.push_back({1'b0, w.imm});
                    exp_wb.push_back({w.rd, 1'b1, w.opcode[3:0]});
                end
                K_STORE:   exp_acc.push_back({1'b1, w.imm});
                default:   illegal_exp++;
            endcase
        end
    endtask

    function automatic logic run_complete();
        return exp_fetch.size() == 0 && exp_acc.size() == 0 && exp_wb.size() == 0
            && obs_fetch.size() == 0 && obs_acc.size() == 0 && obs_wb.size() == 0
            && illegal_seen == illegal_exp;
    endfunction

    //////////////////////////////
    // responders
    //////////////////////////////
    // first accesses are slow so fetches overlap them
    always @(negedge g_clk)
    begin
        if (resp_en)
        begin
            if (i_odv)
                i_odv = 1'b0;
            else if (i_req && served_fetch < NUM_FETCH)
            begin
                if (!i_busy)
                begin
                    i_wait = (served_data < SLOW_ACCESSES) ? 0 : int'(take_bits(3));
                    i_busy = 1'b1;
                end
                if (i_wait == 0)
                begin
                    i_data = imem[i_addr];
                    i_odv  = 1'b1;
                    i_busy = 1'b0;
                    served_fetch++;
                end
                else
                    i_wait--;
            end
            if (d_odv)
                d_odv = 1'b0;
            else if (d_rd || d_wr)
            begin
                if (!d_busy)
                begin
                    d_wait = (served_data < SLOW_ACCESSES) ? 7 : int'(take_bits(3));
                    d_busy = 1'b1;
                end
                if (d_wait == 0)
                begin
                    d_odv  = 1'b1;
                    d_busy = 1'b0;
                    served_data++;
                end
                else
                    d_wait--;
            end
        end
    end

    //////////////////////////////
    // monitors and compare
    //////////////////////////////
    always @(posedge g_clk)
    begin
        if (arst_n)
        begin
            if (i_req && i_odv)
            begin
                obs_fetch.push_back(i_addr);
                if (d_rd || d_wr)
                    overlap_seen = 1'b1;
            end
            if (d_odv && (d_rd || d_wr))
                obs_acc.push_back({d_wr, d_addr});
            if (rf_we)
                obs_wb.push_back({rf_rd, rf_from_mem, alu_op});
            if (illegal)
                illegal_seen++;
        end
    end

    always @(negedge g_clk)
    begin
        if (obs_fetch.size() > 0)
        begin
            if (exp_fetch.size() == 0)
                stop_on_error("fetch seen beyond the expected program");
            else
                check_value("fetch address", obs_fetch.pop_front(), exp_fetch.pop_front());
        end
        if (obs_acc.size() > 0)
        begin
            if (exp_acc.size() == 0)
                stop_on_error("data access seen that the program does not contain");
            else
                check_value("data access {wr, addr}", obs_acc.pop_front(), exp_acc.pop_front());
        end
        if (obs_wb.size() > 0)
        begin
            if (exp_wb.size() == 0)
                stop_on_error("register write seen that the program does not contain");
            else
                check_value("writeback {rd, from_mem, alu_op}", obs_wb.pop_front(),
                    exp_wb.pop_front());
        end
        if (illegal_seen > illegal_exp)
            stop_on_error("more illegal pulses than illegal opcodes");
    end

    initial
    begin
        int cycles;
        g_clk        = 1'b0;
        arst_n       = 1'b0;
        i_data       = '0;
        i_odv        = 1'b0;
        d_odv        = 1'b0;
        lfsr_state   = 32'h380e919a;
        resp_en      = 1'b0;
        i_busy       = 1'b0;
        d_busy       = 1'b0;
        i_wait       = 0;
        d_wait       = 0;
        served_fetch = 0;
        served_data  = 0;
        illegal_seen = 0;
        overlap_seen = 1'b0;
        fill_memory();
        build_expected();

        repeat (3) @(posedge g_clk);
        @(negedge g_clk);
        check_value("i_req in reset", i_req, 0);
        check_value("d_rd in reset", d_rd, 0);
        check_value("d_wr in reset", d_wr, 0);
        check_value("rf_we in reset", rf_we, 0);
        check_value("illegal in reset", illegal, 0);
        check_value("i_addr in reset", i_addr, RESET_PC);
        arst_n = 1'b1;
        @(posedge g_clk);
        resp_en = 1'b1;

        cycles = 0;
        while (!run_complete() && cycles < MAX_WAIT)
        begin
            @(posedge g_clk);
            cycles++;
        end
        if (!run_complete())
            stop_on_error("timeout waiting for the program to retire");

        // quiet period, stray records would show here
        repeat (30) @(posedge g_clk);
        check_value("illegal pulse count", illegal_seen, illegal_exp);
        check_value("fetch completed during a data access", overlap_seen, 1);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== hw/ctrl_top.sv ====
`timescale 1ns/1ns

module ctrl_top #(
    parameter int PC_W     = ctrl_pkg::PC_W_DEF,
    parameter int RESET_PC = 0
) (
    input  logic                          g_clk,
    input  logic                          arst_n,
    output logic                          i_req,
    output logic [PC_W-1:0]               i_addr,
    input  logic [ctrl_pkg::INSTR_W-1:0]  i_data,
    input  logic                          i_odv,
    output logic                          d_rd,
    output logic                          d_wr,
    output logic [ctrl_pkg::IMM_W-1:0]    d_addr,
    input  logic                          d_odv,
    output logic                          rf_we,
    output logic [ctrl_pkg::RD_W-1:0]     rf_rd,
    output logic                          rf_from_mem,
    output logic [ctrl_pkg::ALU_OP_W-1:0] alu_op,
    output logic                          illegal
);
    import ctrl_pkg::*;

    instr_t   i_word;
    logic     pc_step;
    logic     pc_load;
    logic     mem_free;
    logic     mem_push;
    logic     mem_valid;
    logic     mem_pop;
    mem_cmd_t mem_push_data;
    mem_cmd_t mem_pop_data;
    logic     wb_free;
    logic     wb_push;
    logic     wb_valid;
    logic     wb_pop;
    wb_cmd_t  wb_push_data;
    wb_cmd_t  wb_pop_data;

    assign i_word = instr_t'(i_data);

    pc_counter #(
        .PC_W     (PC_W),
        .RESET_PC (RESET_PC)
    ) u_pc (
        .g_clk      (g_clk),
        .arst_n     (arst_n),
        .step       (pc_step),
        .load       (pc_load),
        .load_value (i_data[PC_W-1:0]),
        .pc         (i_addr)
    );

    fetch_fsm #(
        .PC_W (PC_W)
    ) u_fetch (
        .g_clk     (g_clk),
        .arst_n    (arst_n),
        .i_req     (i_req),
        .i_data    (i_word),
        .i_odv     (i_odv),
        .pc_step   (pc_step),
        .pc_load   (pc_load),
        .slot_free (mem_free),
        .slot_push (mem_push),
        .slot_data (mem_push_data),
        .illegal   (illegal)
    );

    stage_slot #(
        .payload_t (mem_cmd_t)
    ) mem_slot (
        .g_clk     (g_clk),
        .arst_n    (arst_n),
        .push      (mem_push),
        .push_data (mem_push_data),
        .free      (mem_free),
        .pop       (mem_pop),
        .valid     (mem_valid),
        .pop_data  (mem_pop_data)
    );

    mem_fsm u_mem (
        .g_clk      (g_clk),
        .arst_n     (arst_n),
        .slot_valid (mem_valid),
        .slot_pop   (mem_pop),
        .slot_data  (mem_pop_data),
        .d_rd       (d_rd),
        .d_wr       (d_wr),
        .d_addr     (d_addr),
        .d_odv      (d_odv),
        .wb_free    (wb_free),
        .wb_push    (wb_push),
        .wb_data    (wb_push_data)
    );

    stage_slot #(
        .payload_t (wb_cmd_t)
    ) wb_slot (
        .g_clk     (g_clk),
        .arst_n    (arst_n),
        .push      (wb_push),
        .push_data (wb_push_data),
        .free      (wb_free),
        .pop       (wb_pop),
        .valid     (wb_valid),
        .pop_data  (wb_pop_data)
    );

    //////////////////////////////
    // register file writeback
    //////////////////////////////
    // drained every valid cycle
    assign wb_pop      = wb_valid;
    assign rf_we       = wb_valid & wb_pop;
    assign rf_rd       = wb_pop_data.rd;
    assign rf_from_mem = wb_pop_data.from_mem;
    assign alu_op      = wb_pop_data.alu_op;

endmodule

// ==== hw/mem_fsm.sv ====
`timescale 1ns/1ns

module mem_fsm (
    input  logic                        g_clk,
    input  logic                        arst_n,
    input  logic                        slot_valid,
    output logic                        slot_pop,
    input  ctrl_pkg::mem_cmd_t          slot_data,
    output logic                        d_rd,
    output logic                        d_wr,
    output logic [ctrl_pkg::IMM_W-1:0]  d_addr,
    input  logic                        d_odv,
    input  logic                        wb_free,
    output logic                        wb_push,
    output ctrl_pkg::wb_cmd_t           wb_data
);
    import ctrl_pkg::*;

    typedef enum logic [1:0] {
        M_IDLE   = 2'd0,
        M_ACCESS = 2'd1,
        M_WB     = 2'd2
    } state_e;

    state_e   state;
    state_e   state_nxt;
    mem_cmd_t cmd_q;

    always_ff @(posedge g_clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= M_IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge g_clk)
    begin
        if (slot_pop)
            cmd_q <= slot_data;
    end

    assign d_addr  = cmd_q.addr;
    assign wb_data = '{rd: cmd_q.rd, from_mem: cmd_q.from_mem, alu_op: cmd_q.alu_op};

    always_comb
    begin
        state_nxt = state;
        slot_pop  = 1'b0;
        d_rd      = 1'b0;
        d_wr      = 1'b0;
        wb_push   = 1'b0;
        case (state)
            M_IDLE:
            begin
                if (slot_valid)
                begin
                    slot_pop = 1'b1;
                    // compute goes straight to writeback
                    if (slot_data.rd_en || slot_data.wr_en)
                        state_nxt = M_ACCESS;
                    else if (slot_data.wb_en)
                        state_nxt = M_WB;
                end
            end
            M_ACCESS:
            begin
                d_rd = cmd_q.rd_en;
                d_wr = cmd_q.wr_en;
                if (d_odv)
                begin
                    if (cmd_q.wb_en)
                        state_nxt = M_WB;
                    else
                        state_nxt = M_IDLE;
                end
            end
            M_WB:
            begin
                if (wb_free)
                begin
                    wb_push   = 1'b1;
                    state_nxt = M_IDLE;
                end
            end
            default:
            begin
                state_nxt = M_IDLE;
            end
        endcase
    end

    // relies on the decoder never flagging both
    a_rd_wr_excl: assert property (
        @(posedge g_clk) disable iff (!arst_n)
        !(d_rd && d_wr)
    );

endmodule

// ==== hw/fetch_fsm.sv ====
`timescale 1ns/1ns

module fetch_fsm #(
    parameter int PC_W = ctrl_pkg::PC_W_DEF
) (
    input  logic               g_clk,
    input  logic               arst_n,
    output logic               i_req,
    input  ctrl_pkg::instr_t   i_data,
    input  logic               i_odv,
    output logic               pc_step,
    output logic               pc_load,
    input  logic               slot_free,
    output logic               slot_push,
    output ctrl_pkg::mem_cmd_t slot_data,
    output logic               illegal
);
    import ctrl_pkg::*;

    typedef enum logic [1:0] {
        S_REQ   = 2'd0,
        S_DEC   = 2'd1,
        S_JREQ  = 2'd2,
        S_ISSUE = 2'd3
    } state_e;

    state_e    state;
    state_e    state_nxt;
    instr_t    instr_q;
    op_class_e dec_class;
    logic      dec_jump;
    logic      run_q;

    // jump target comes from the low bits of the second word
    if (PC_W > $bits(instr_t))
    begin : g_pc_w_check
        $error("PC_W wider than the instruction word");
    end

    op_decoder u_dec (
        .instr    (instr_q),
        .op_class (dec_class),
        .is_jump  (dec_jump),
        .cmd      (slot_data)
    );

    always_ff @(posedge g_clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= S_REQ;
        else
            state <= state_nxt;
    end

    // first request waits one cycle out of reset
    always_ff @(posedge g_clk or negedge arst_n)
    begin
        if (!arst_n)
            run_q <= 1'b0;
        else
            run_q <= 1'b1;
    end

    always_ff @(posedge g_clk)
    begin
        if (state == S_REQ && run_q && i_odv)
            instr_q <= i_data;
    end

    //////////////////////////////
    // next state and outputs
    //////////////////////////////
    always_comb
    begin
        state_nxt = state;
        i_req     = 1'b0;
        pc_step   = 1'b0;
        pc_load   = 1'b0;
        slot_push = 1'b0;
        illegal   = 1'b0;
        case (state)
            S_REQ:
            begin
                i_req = run_q;
                if (run_q && i_odv)
                begin
                    pc_step   = 1'b1;
                    state_nxt = S_DEC;
                end
            end
            S_DEC:
            begin
                if (dec_jump)
                begin
                    state_nxt = S_JREQ;
                end
                else if (dec_class == CLS_ILLEGAL)
                begin
                    illegal   = 1'b1;
                    state_nxt = S_REQ;
                end
                else if (slot_free)
                begin
                    slot_push = 1'b1;
                    state_nxt = S_REQ;
                end
                else
                begin
                    state_nxt = S_ISSUE;
                end
            end
            S_JREQ:
            begin
                i_req = 1'b1;
                if (i_odv)
                begin
                    pc_load   = 1'b1;
                    state_nxt = S_REQ;
                end
            end
            S_ISSUE:
            begin
                if (slot_free)
                begin
                    slot_push = 1'b1;
                    state_nxt = S_REQ;
                end
            end
            default:
            begin
                state_nxt = S_REQ;
            end
        endcase
    end

    a_req_until_odv: assert property (
        @(posedge g_clk) disable iff (!arst_n)
        i_req && !i_odv |=> i_req
    );

endmodule

// ==== hw/stage_slot.sv ====
`timescale 1ns/1ns

module stage_slot #(
    parameter type payload_t = logic
) (
    input  logic     g_clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     free,
    input  logic     pop,
    output logic     valid,
    output payload_t pop_data
);

    logic     full;
    payload_t data_q;

    // occupancy, push and pop never meet in one cycle
    always_ff @(posedge g_clk or negedge arst_n)
    begin
        if (!arst_n)
            full <= 1'b0;
        else if (push)
            full <= 1'b1;
        else if (pop)
            full <= 1'b0;
    end

    always_ff @(posedge g_clk)
    begin
        if (push)
            data_q <= push_data;
    end

    assign free     = !full;
    assign valid    = full;
    assign pop_data = data_q;

    // producer must respect back-pressure
    a_no_push_when_full: assert property (
        @(posedge g_clk) disable iff (!arst_n)
        push |-> free
    );

endmodule

// ==== hw/op_decoder.sv ====
`timescale 1ns/1ns

module op_decoder (
    input  ctrl_pkg::instr_t    instr,
    output ctrl_pkg::op_class_e op_class,
    output logic                is_jump,
    output ctrl_pkg::mem_cmd_t  cmd
);
    import ctrl_pkg::*;

    opcode_t op;

    assign op = instr.opcode;

    //////////////////////////////
    // opcode ranges
    //////////////////////////////
    always_comb
    begin
        is_jump = (op == OP_JUMP);
        if (op < OP_LOAD_BASE)
            op_class = CLS_COMPUTE;
        else if (op < OP_STORE_BASE)
            op_class = CLS_LOAD;
        else if (op < OP_JUMP)
            op_class = CLS_STORE;
        else if (is_jump)
            // rides on compute, fetch checks is_jump first
            op_class = CLS_COMPUTE;
        else
            op_class = CLS_ILLEGAL;
    end

    //////////////////////////////
    // memory stage command
    //////////////////////////////
    always_comb
    begin
        cmd          = '0;
        cmd.addr     = instr.imm;
        cmd.rd       = instr.rd;
        cmd.alu_op   = op[ALU_OP_W-1:0];
        case (op_class)
            CLS_COMPUTE:
            begin
                cmd.wb_en = !is_jump;
            end
            CLS_LOAD:
            begin
                cmd.rd_en    = 1'b1;
                cmd.wb_en    = 1'b1;
                cmd.from_mem = 1'b1;
            end
            CLS_STORE:
            begin
                cmd.wr_en = 1'b1;
            end
            default:
            begin
                cmd.wb_en = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/pc_counter.sv ====
`timescale 1ns/1ns

module pc_counter #(
    parameter int PC_W     = ctrl_pkg::PC_W_DEF,
    parameter int RESET_PC = 0
) (
    input  logic            g_clk,
    input  logic            arst_n,
    input  logic            step,
    input  logic            load,
    input  logic [PC_W-1:0] load_value,
    output logic [PC_W-1:0] pc
);

    // jump load wins over the ordinary step
    always_ff @(posedge g_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= PC_W'(RESET_PC);
        end
        else if (load)
        begin
            pc <= load_value;
        end
        else if (step)
        begin
            pc <= pc + PC_W'(1);
        end
    end

endmodule

// ==== hw/ctrl_pkg.sv ====
package ctrl_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int INSTR_W  = 16;
    localparam int OPCODE_W = 6;
    localparam int RD_W     = 3;
    localparam int IMM_W    = 7;
    localparam int ALU_OP_W = 4;
    localparam int PC_W_DEF = 8;

    //////////////////////////////
    // instruction layout
    //////////////////////////////
    typedef logic [OPCODE_W-1:0] opcode_t;

    // opcode 15..10, rd 9..7, imm 6..0
    typedef struct packed {
        opcode_t             opcode;
        logic [RD_W-1:0]     rd;
        logic [IMM_W-1:0]    imm;
    } instr_t;

    // jump has no class, see is_jump in the decoder
    typedef enum logic [1:0] {
        CLS_COMPUTE = 2'd0,
        CLS_LOAD    = 2'd1,
        CLS_STORE   = 2'd2,
        CLS_ILLEGAL = 2'd3
    } op_class_e;

    localparam opcode_t OP_LOAD_BASE  = 6'd16;
    localparam opcode_t OP_STORE_BASE = 6'd20;
    localparam opcode_t OP_JUMP       = 6'd24;

    //////////////////////////////
    // stage commands
    //////////////////////////////
    typedef struct packed {
        logic                rd_en;
        logic                wr_en;
        logic [IMM_W-1:0]    addr;
        logic                wb_en;
        logic [RD_W-1:0]     rd;
        logic                from_mem;
        logic [ALU_OP_W-1:0] alu_op;
    } mem_cmd_t;

    typedef struct packed {
        logic [RD_W-1:0]     rd;
        logic                from_mem;
        logic [ALU_OP_W-1:0] alu_op;
    } wb_cmd_t;

endpackage
